// ==== rtl/mult_pkg.sv ====
package mult_pkg;

    // Operand and product widths
    localparam int OPERAND_W = 16;             // Each multiplier input
    localparam int PRODUCT_W = 2 * OPERAND_W;  // Full unsigned product, no truncation

    // Pipeline depth after the operand register
    // Stage 1 holds the product, later stages only delay it
    localparam int MULT_STAGES = 2;

    // Unsigned operand as presented on req
    typedef logic [OPERAND_W-1:0] operand_t;

    // Unsigned product, also the word stored in the buffer RAM
    typedef logic [PRODUCT_W-1:0] product_t;

    // Operand pair sampled together with en_mult
    typedef struct packed {
        operand_t a;  // Multiplicand
        operand_t b;  // Multiplier
    } mult_req_t;

endpackage

// ==== rtl/buf_pkg.sv ====
package buf_pkg;

    import mult_pkg::*;

    // Buffer geometry
    localparam int BUF_DEPTH  = 64;                 // Products per fill
    localparam int BUF_ADDR_W = $clog2(BUF_DEPTH);  // 6 bits for 64 entries

    // RAM address
    typedef logic [BUF_ADDR_W-1:0] buf_addr_t;

    // Counter range 0..BUF_DEPTH, one bit wider than the address
    typedef logic [BUF_ADDR_W:0] buf_count_t;

    // Counter compare points
    localparam buf_count_t BUF_FULL_CNT = buf_count_t'(BUF_DEPTH);      // All entries used
    localparam buf_count_t BUF_LAST_CNT = buf_count_t'(BUF_DEPTH - 1);  // Last entry index

    // RAM write port
    typedef struct packed {
        logic      en;    // Write strobe
        buf_addr_t addr;  // Entry to write
        product_t  data;  // Product to store
    } ram_wr_t;

    // RAM read port, data comes back one cycle later
    typedef struct packed {
        logic      en;    // Read strobe
        buf_addr_t addr;  // Entry to read
    } ram_rd_t;

    // Controller states
    typedef enum logic [1:0] {
        IDLE     = 2'b00,  // Empty, waiting for the first operand pair
        FILLING  = 2'b01,  // Accepting pairs, products landing in RAM
        FULL     = 2'b10,  // All entries written, waiting for en_read_mem
        DRAINING = 2'b11   // Burst of BUF_DEPTH words on mem_val
    } buf_state_t;

endpackage

// ==== rtl/mult_pipe.sv ====
module mult_pipe (
    input  logic                clk,
    input  logic                rst_n,
    input  mult_pkg::mult_req_t req,
    input  logic                take,        // Accept pulse from the controller
    output mult_pkg::product_t  prod,
    output logic                prod_valid
);

    import mult_pkg::*;

    // Operand launch register
    mult_req_t op_q;
    logic      op_vld_q;

    // Product stages with the multiply in index 0
    product_t               stage_q [MULT_STAGES];
    logic [MULT_STAGES-1:0] stage_vld_q;

    // Operands only load on an accepted pair
    always_ff @(posedge clk) begin
        if (take) op_q <= req;
    end

    // Multiply stage then delay stages
    always_ff @(posedge clk) begin
        stage_q[0] <= product_t'(op_q.a) * product_t'(op_q.b);  // Stage 1 multiply
        for (int i = 1; i < MULT_STAGES; i++) begin
            stage_q[i] <= stage_q[i-1];  // Delay stages
        end
    end

    // Valid bits travel alongside the data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_vld_q    <= 1'b0;
            stage_vld_q <= '0;
        end else begin
            op_vld_q    <= take;
            stage_vld_q <= {stage_vld_q[MULT_STAGES-2:0], op_vld_q};  // Shift toward output
        end
    end

    // Last stage drives the controller
    assign prod       = stage_q[MULT_STAGES-1];
    assign prod_valid = stage_vld_q[MULT_STAGES-1];

endmodule

// ==== rtl/product_ram.sv ====
module product_ram #(
    parameter type word_t = mult_pkg::product_t,  // Stored payload
    parameter int  DEPTH  = buf_pkg::BUF_DEPTH    // Number of entries
) (
    input  logic             clk,
    input  buf_pkg::ram_wr_t wr,       // Write port, same clock
    input  buf_pkg::ram_rd_t rd,       // Read port
    output word_t            rd_data   // Valid one cycle after rd.en
);

    // Behavioral storage array
    word_t mem [DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // Registered read port
    // Holds the last word while rd.en is low
    always_ff @(posedge clk) begin
        if (rd.en) begin
            rd_data <= mem[rd.addr];
        end
    end

endmodule

// ==== rtl/buffer_ctrl.sv ====
module buffer_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               en_mult,        // Operand strobe from the caller
    input  logic               en_read_mem,    // Burst request
    input  mult_pkg::product_t prod,           // Product from the pipeline
    input  logic               prod_valid,
    output logic               take,           // Accepted pair, fed to mult_pipe
    output buf_pkg::ram_wr_t   ram_wr,
    output buf_pkg::ram_rd_t   ram_rd,
    output logic               rdy_mult,
    output logic               rdy_read_mem,
    output logic               valid_mem_val
);

    import buf_pkg::*;

    // FSM
    buf_state_t state_q;
    buf_state_t state_d;

    // Counters, all cleared at the end of a burst
    buf_count_t acc_cnt_q;  // Pairs accepted this round
    buf_count_t wr_cnt_q;   // Products written to RAM
    buf_count_t rd_cnt_q;   // Read addresses issued

    // Read data valid, one cycle behind the read strobe
    logic rd_vld_q;

    // Decoded conditions
    logic acc_full;     // No more room for accepts
    logic wr_last;      // Final entry written at this edge
    logic rd_issue;     // Read address goes out this cycle
    logic drain_start;  // Burst request taken
    logic drain_done;   // Last word on mem_val this cycle

    // Acceptance closes once every entry is claimed
    // Products still in flight already own an entry
    assign acc_full = (acc_cnt_q == BUF_FULL_CNT);

    // Ready levels decoded from state
    assign rdy_mult     = ((state_q == IDLE) || (state_q == FILLING)) && !acc_full;
    assign rdy_read_mem = (state_q == FULL);

    // Handshake-free strobes, ignored outside their window
    assign take        = en_mult && rdy_mult;
    assign drain_start = en_read_mem && rdy_read_mem;

    assign wr_last = prod_valid && (wr_cnt_q == BUF_LAST_CNT);

    // Reads run through addresses 0..DEPTH-1 once
    assign rd_issue = (state_q == DRAINING) && (rd_cnt_q != BUF_FULL_CNT);

    // Final word is out when all addresses went and the last one returned
    assign drain_done = (state_q == DRAINING) && rd_vld_q && (rd_cnt_q == BUF_FULL_CNT);

    // RAM write port straight from the pipeline output
    always_comb begin
        ram_wr.en   = prod_valid;
        ram_wr.addr = wr_cnt_q[BUF_ADDR_W-1:0];  // Write order = arrival order
        ram_wr.data = prod;
    end

    // RAM read port
    always_comb begin
        ram_rd.en   = rd_issue;
        ram_rd.addr = rd_cnt_q[BUF_ADDR_W-1:0];  // Same order as written
    end

    assign valid_mem_val = rd_vld_q;  // Aligned with the registered RAM output

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (take) state_d = FILLING;  // First pair of a round
            end
            FILLING: begin
                if (wr_last) state_d = FULL;  // Count reaches BUF_DEPTH at this edge
            end
            FULL: begin
                if (drain_start) state_d = DRAINING;
            end
            DRAINING: begin
                if (drain_done) state_d = IDLE;
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Accept counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_cnt_q <= '0;
        end else if (drain_done) begin
            acc_cnt_q <= '0;  // New round
        end else if (take) begin
            acc_cnt_q <= acc_cnt_q + 1'b1;
        end
    end

    // Write counter, doubles as the write address
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_cnt_q <= '0;
        end else if (drain_done) begin
            wr_cnt_q <= '0;
        end else if (prod_valid) begin
            wr_cnt_q <= wr_cnt_q + 1'b1;  // Never passes BUF_DEPTH, accepts are capped
        end
    end

    // Read counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_cnt_q <= '0;
        end else if (drain_done) begin
            rd_cnt_q <= '0;
        end else if (rd_issue) begin
            rd_cnt_q <= rd_cnt_q + 1'b1;
        end
    end

    // Valid flag tracks RAM read latency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_vld_q <= 1'b0;
        end else begin
            rd_vld_q <= rd_issue;
        end
    end

endmodule

// ==== rtl/mult_buffer_top.sv ====
module mult_buffer_top (
    input  logic                clk,
    input  logic                rst_n,
    input  mult_pkg::mult_req_t req,            // Operand pair
    input  logic                en_mult,        // Operand strobe
    input  logic                en_read_mem,    // Burst request
    output logic                rdy_mult,       // Buffer accepting operands
    output logic                rdy_read_mem,   // Buffer full, burst may start
    output mult_pkg::product_t  mem_val,        // Burst data
    output logic                valid_mem_val   // Qualifies mem_val
);

    import mult_pkg::*;
    import buf_pkg::*;

    // Pipeline to controller
    logic     take;        // Accept pulse back into the pipeline
    product_t prod;
    logic     prod_valid;

    // Controller to RAM
    ram_wr_t ram_wr;
    ram_rd_t ram_rd;

    // Multiplier pipeline
    mult_pipe i_mult_pipe (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .take       (take),
        .prod       (prod),
        .prod_valid (prod_valid)
    );

    // Counters, FSM and port control
    buffer_ctrl i_buffer_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .en_mult       (en_mult),
        .en_read_mem   (en_read_mem),
        .prod          (prod),
        .prod_valid    (prod_valid),
        .take          (take),
        .ram_wr        (ram_wr),
        .ram_rd        (ram_rd),
        .rdy_mult      (rdy_mult),
        .rdy_read_mem  (rdy_read_mem),
        .valid_mem_val (valid_mem_val)
    );

    // Product storage, read data goes straight out
    product_ram #(
        .word_t (product_t),
        .DEPTH  (BUF_DEPTH)
    ) i_product_ram (
        .clk     (clk),
        .wr      (ram_wr),
        .rd      (ram_rd),
        .rd_data (mem_val)
    );

endmodule

// ==== bench/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Expected product, full 32-bit unsigned result of the two operands
function automatic product_t ref_product(input operand_t a, input operand_t b);
    product_t wide_a;
    product_t wide_b;
    wide_a = {16'h0000, a};  // Zero extend, operands are unsigned
    wide_b = {16'h0000, b};
    return wide_a * wide_b;
endfunction

// Data word compare
task automatic check_product(input string name, input product_t got, input product_t exp);
    chk_cnt++;
    if (got !== exp) begin
        err_cnt++;
        $display("Mismatch %s at %0t: got %h expected %h", name, $time, got, exp);
    end
endtask

// Single-bit level compare
task automatic check_flag(input string name, input logic got, input logic exp);
    chk_cnt++;
    if (got !== exp) begin
        err_cnt++;
        $display("Mismatch %s at %0t: got %h expected %h", name, $time, got, exp);
    end
endtask

// Failures that are not a wrong value
task automatic note_failure(input string msg);
    err_cnt++;
    $display("Error at %0t: %s", $time, msg);
endtask

`endif

// ==== bench/tb_mult_buffer.sv ====
module tb_mult_buffer;

    timeunit 1ns;
    timeprecision 1ps;

    import mult_pkg::*;
    import buf_pkg::*;

    localparam int CLK_PERIOD  = 10;
    localparam int RST_CYCLES  = 5;
    localparam int NUM_FILLS   = 7;              // Tests 2..5 once, test 6 three times
    localparam int GAP_ALLOW   = BUF_DEPTH + 30; // Random gaps plus waits for the ready flags
    localparam int FILL_BUDGET = BUF_DEPTH + GAP_ALLOW + 70;
    localparam int WATCHDOG_NS = (RST_CYCLES + 20 + NUM_FILLS * FILL_BUDGET) * CLK_PERIOD;
    localparam int RDY_LIMIT   = 20;             // Cycles allowed for rdy_read_mem to rise
    localparam int BURST_LIMIT = BUF_DEPTH + 16; // Cycles allowed for the burst to finish

    logic      clk;
    logic      rst_n;
    mult_req_t req;
    logic      en_mult;
    logic      en_read_mem;
    logic      rdy_mult;
    logic      rdy_read_mem;
    product_t  mem_val;
    logic      valid_mem_val;

    int          err_cnt = 0;
    int          chk_cnt = 0;
    logic [31:0] lfsr_q  = 32'h69400193;
    product_t    exp_q [$];      // Products in accept order
    int          acc_cnt = 0;    // Model of accepted pairs this round
    int          vcnt = 0;       // Valid words seen in the current burst
    bit          burst_armed = 0;

    `include "tb_checks.svh"

    mult_buffer_top i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (req),
        .en_mult       (en_mult),
        .en_read_mem   (en_read_mem),
        .rdy_mult      (rdy_mult),
        .rdy_read_mem  (rdy_read_mem),
        .mem_val       (mem_val),
        .valid_mem_val (valid_mem_val)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    // Monitor and reference queue, samples pre-edge values
    always @(posedge clk) begin
        if (rst_n) begin
            check_flag("rdy_mult", rdy_mult, acc_cnt < BUF_DEPTH);
            if (acc_cnt < BUF_DEPTH) check_flag("rdy_read_mem", rdy_read_mem, 1'b0);
            if (en_mult && (acc_cnt < BUF_DEPTH)) begin
                exp_q.push_back(ref_product(req.a, req.b));  // Pair accepted here
                acc_cnt++;
            end
            if (valid_mem_val) begin
                if (!burst_armed) note_failure("valid_mem_val high without an accepted read");
                if (exp_q.size() == 0) begin
                    note_failure("valid word on mem_val with no expected product left");
                end else begin
                    check_product("mem_val", mem_val, exp_q.pop_front());
                end
                vcnt++;
                if (vcnt == BUF_DEPTH) begin
                    acc_cnt     = 0;  // Buffer empty, accepting again
                    burst_armed = 0;
                end
            end else if (vcnt != 0) begin
                if (vcnt != BUF_DEPTH) begin
                    note_failure($sformatf("burst had %0d words instead of %0d", vcnt, BUF_DEPTH));
                end
                vcnt = 0;
            end
        end
    end

    // Drives pairs until 64 are taken
    task automatic fill_buffer(input bit gaps, input bit corners, input bit hold);
        int       taken;
        int       k;
        operand_t a;
        operand_t b;
        taken = 0;
        k     = 0;
        while (taken < BUF_DEPTH) begin
            @(posedge clk);
            if (en_mult && rdy_mult) taken++;
            if (taken < BUF_DEPTH) begin
                if (gaps && (rand_bits(2) == 2'b00)) begin
                    en_mult <= 1'b0;  // Random idle cycle
                end else begin
                    a = operand_t'(rand_bits(16));
                    b = operand_t'(rand_bits(16));
                    if (corners && (k == 0)) a = 16'h0000;
                    if (corners && (k == 1)) begin
                        a = 16'hffff;
                        b = 16'hffff;
                    end
                    if (corners && (k == 2)) b = 16'h0000;
                    req.a   <= a;
                    req.b   <= b;
                    en_mult <= 1'b1;
                    k++;
                end
            end
        end
        en_mult <= hold;  // Held high to probe the full buffer
        if (hold) begin
            en_read_mem <= 1'b1;  // Early pulse, buffer not yet full
            @(posedge clk);
            check_flag("rdy_read_mem", rdy_read_mem, 1'b0);
            en_read_mem <= 1'b0;
        end
    endtask

    // Waits for the full flag, requests the burst, checks its shape
    task automatic drain_buffer(input int delay);
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while ((rdy_read_mem !== 1'b1) && (waited < RDY_LIMIT));
        if (rdy_read_mem !== 1'b1) begin
            note_failure("rdy_read_mem did not rise after the fill");
            return;
        end
        en_mult <= 1'b0;
        if (exp_q.size() != BUF_DEPTH) begin
            note_failure($sformatf("%0d products queued at full, not %0d",
                exp_q.size(), BUF_DEPTH));
        end
        repeat (delay) begin
            @(posedge clk);
            check_flag("rdy_read_mem", rdy_read_mem, 1'b1);  // Stays full until asked
            check_flag("valid_mem_val", valid_mem_val, 1'b0);
        end
        burst_armed = 1'b1;
        en_read_mem <= 1'b1;
        @(posedge clk);  // Request taken here
        en_read_mem <= 1'b0;
        @(posedge clk);
        check_flag("rdy_read_mem", rdy_read_mem, 1'b0);
        check_flag("valid_mem_val", valid_mem_val, 1'b0);  // RAM latency
        @(posedge clk);
        check_flag("valid_mem_val", valid_mem_val, 1'b1);  // First word
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while ((rdy_mult !== 1'b1) && (waited < BURST_LIMIT));
        if (rdy_mult !== 1'b1) note_failure("rdy_mult did not return after the burst");
        if (exp_q.size() != 0) begin
            note_failure($sformatf("%0d expected products never came out", exp_q.size()));
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        $display("%-28s %s", name, (err_cnt == errs_before) ? "ok" : "errors");
    endtask

    // Test sequence
    initial begin
        int errs;
        int round;
        rst_n       = 1'b0;
        en_mult     = 1'b0;
        en_read_mem = 1'b0;
        req         = '0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        errs = err_cnt;
        @(posedge clk);
        check_flag("rdy_mult", rdy_mult, 1'b1);
        check_flag("rdy_read_mem", rdy_read_mem, 1'b0);
        check_flag("valid_mem_val", valid_mem_val, 1'b0);
        finish_test("1 reset state", errs);

        errs = err_cnt;
        fill_buffer(1'b0, 1'b1, 1'b0);  // Corner operands up front
        drain_buffer(0);
        finish_test("2 back-to-back fill", errs);

        errs = err_cnt;
        fill_buffer(1'b1, 1'b0, 1'b0);
        drain_buffer(0);
        finish_test("3 gapped fill", errs);

        errs = err_cnt;
        fill_buffer(1'b0, 1'b0, 1'b1);
        drain_buffer(0);
        finish_test("4 full behavior", errs);

        errs = err_cnt;
        fill_buffer(1'b1, 1'b1, 1'b0);
        drain_buffer(5);  // Late read request
        finish_test("5 burst shape", errs);

        errs = err_cnt;
        for (round = 0; round < 3; round++) begin
            fill_buffer(round[0], 1'b0, 1'b0);  // Alternate gapped rounds
            drain_buffer(round);
        end
        finish_test("6 repeat rounds", errs);

        repeat (4) @(posedge clk);
        $display("Checks: %0d  errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog, limit scales with the number of fills
    initial begin
        #(WATCHDOG_NS);
        $display("Error: simulation did not finish within %0d ns", WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+bench
rtl/mult_pkg.sv
rtl/buf_pkg.sv
rtl/mult_pipe.sv
rtl/product_ram.sv
rtl/buffer_ctrl.sv
rtl/mult_buffer_top.sv
bench/tb_mult_buffer.sv
